// ==== project.f ====
verilog/ddr_app_pkg.sv
verilog/ddr_test_pkg.sv
verilog/ddr_calib_seq.sv
verilog/ddr_app_mem.sv
verilog/ddr_traffic_gen.sv
verilog/ddr_rd_checker.sv
verilog/ddr_test_top.sv
tests/ddr_test_props.sv
tests/ddr_test_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the DDR4 memory test testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module ddr_test_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vddr_test_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Testbench passed"; then
  exit 0
fi
echo "Simulation did not report success"
exit 1

// ==== tests/ddr_test_props.sv ====
// Application interface timing assertions for the memory controller stand-in
`timescale 1ns/1ps

module ddr_test_props (
  input logic                  c0_ddr4_clk,
  input logic                  rst_n_i,
  input logic                  app_en_i,
  input ddr_app_pkg::app_req_t app_req_i,
  input logic                  app_rdy_i,
  input logic                  rd_valid_i
);
  import ddr_app_pkg::*;

  int   win_cnt;
  logic rd_accept;

  // Position in the refresh window since reset release
  always_ff @(posedge c0_ddr4_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      win_cnt <= 0;
    end else if (win_cnt == REFRESH_PERIOD - 1) begin
      win_cnt <= 0;
    end else begin
      win_cnt <= win_cnt + 1;
    end
  end

  assign rd_accept = app_en_i && app_rdy_i && (app_req_i.cmd == APP_CMD_READ);

  refresh_stall: assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    app_rdy_i == (win_cnt >= REFRESH_LEN))
    else $error("app_rdy does not follow the refresh window");

  read_latency: assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    rd_valid_i == $past(rd_accept, READ_LATENCY))
    else $error("rd_valid does not follow read acceptance by the read latency");

  // A stalled request stays on the bus unchanged
  req_hold: assert property (@(posedge c0_ddr4_clk) disable iff (!rst_n_i)
    (app_en_i && !app_rdy_i) |=> (app_en_i && app_req_i == $past(app_req_i)))
    else $error("stalled request changed before acceptance");

endmodule

bind ddr_app_mem ddr_test_props u_props (
  .c0_ddr4_clk (c0_ddr4_clk),
  .rst_n_i     (rst_n_i),
  .app_en_i    (app_en_i),
  .app_req_i   (app_req_i),
  .app_rdy_i   (app_rdy_o),
  .rd_valid_i  (rd_valid_o)
);

// ==== tests/ddr_test_tb.sv ====
// Testbench for the DDR4 memory test subsystem, checked against a shadow-memory model
`timescale 1ns/1ps

module ddr_test_tb;
  import ddr_app_pkg::*;
  import ddr_test_pkg::*;

  logic          c0_ddr4_clk;
  logic          rst_n_i;
  logic          start_i;
  test_mode_e    op_mode_i;
  pattern_seed_t pattern_seed_i;
  app_addr_t     word_count_i;
  logic          init_calib_complete_o;
  logic          busy_o;
  logic          done_o;
  logic          data_compare_error_o;
  logic          check_valid_o;
  chk_result_t   check_o;

  integer        rand_seed;
  int            budget_cycles;
  bit            budget_ready;
  logic          err_expected;
  app_data_t     shadow_mem [MEM_DEPTH];
  test_mode_e    run_mode_q [$];
  pattern_seed_t run_seed_q [$];
  int            run_count_q [$];
  bit            run_noisy_q [$];

  ddr_test_top UUT (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_n_i               (rst_n_i),
    .start_i               (start_i),
    .op_mode_i             (op_mode_i),
    .pattern_seed_i        (pattern_seed_i),
    .word_count_i          (word_count_i),
    .init_calib_complete_o (init_calib_complete_o),
    .busy_o                (busy_o),
    .done_o                (done_o),
    .data_compare_error_o  (data_compare_error_o),
    .check_valid_o         (check_valid_o),
    .check_o               (check_o)
  );

  always #5 c0_ddr4_clk = ~c0_ddr4_clk;

  //**********************************************************
  // Model and checks
  //**********************************************************
  // Upper half seed XOR address, lower half inverted seed plus address
  function automatic app_data_t model_word(pattern_seed_t seed, int addr);
    logic [31:0] a;
    a = addr;
    return {seed ^ a, (~seed) + a};
  endfunction

  task automatic stop_on_error(input string msg);
    $display("[FAIL] time %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      stop_on_error($sformatf("%s: got %b, expected %b", what, actual, expected));
    end
  endtask

  task automatic check_result(input chk_result_t actual, input chk_result_t expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("check result: got addr %0d data %h exp %h mis %b, %s",
                              actual.addr, actual.rdata, actual.expected, actual.mismatch,
                              $sformatf("expected addr %0d data %h exp %h mis %b",
                                        expected.addr, expected.rdata, expected.expected,
                                        expected.mismatch)));
    end
  endtask

  // Queue one run and grow the watchdog budget by its worst-case length
  task automatic add_run(input test_mode_e mode, input pattern_seed_t seed, input int count,
                         input bit noisy);
    run_mode_q.push_back(mode);
    run_seed_q.push_back(seed);
    run_count_q.push_back(count);
    run_noisy_q.push_back(noisy);
    budget_cycles += 2 * count + 20;
    budget_cycles += ((2 * count) / (REFRESH_PERIOD - REFRESH_LEN) + 1) * REFRESH_LEN;
  endtask

  task automatic run_test(input test_mode_e mode, input pattern_seed_t seed, input int count,
                          input bit noisy);
    int          r;
    int          results;
    bit          done_seen;
    logic        valid_prev;
    logic        mism_seen;
    chk_result_t exp_res;
    results    = 0;
    done_seen  = 1'b0;
    valid_prev = 1'b0;
    mism_seen  = 1'b0;
    // Error from the previous run is still held
    @(negedge c0_ddr4_clk);
    check_flag(busy_o, 1'b0, "busy while idle");
    check_flag(data_compare_error_o, err_expected, "sticky error before start");
    @(posedge c0_ddr4_clk);
    start_i        <= 1'b1;
    op_mode_i      <= mode;
    pattern_seed_i <= seed;
    word_count_i   <= app_addr_t'(count);
    @(posedge c0_ddr4_clk);
    start_i <= 1'b0;
    if (mode == MODE_WRITE_READ) begin
      for (int a = 0; a < count; a++) begin
        shadow_mem[a] = model_word(seed, a);
      end
    end
    @(negedge c0_ddr4_clk);
    while (!done_seen) begin
      if (check_valid_o) begin
        if (results >= count) begin
          stop_on_error("more check results than words in the run");
        end
        exp_res.addr     = app_addr_t'(results);
        exp_res.rdata    = shadow_mem[results];
        exp_res.expected = model_word(seed, results);
        exp_res.mismatch = (exp_res.rdata != exp_res.expected);
        check_result(check_o, exp_res);
        mism_seen = mism_seen | exp_res.mismatch;
        results++;
      end
      check_flag(data_compare_error_o, mism_seen, "data compare error flag");
      if (done_o) begin
        check_flag(valid_prev, 1'b1, "done one cycle after the last result");
        check_flag(busy_o, 1'b0, "busy falls with done");
        if (results != count) begin
          stop_on_error($sformatf("run ended after %0d of %0d results", results, count));
        end
        done_seen = 1'b1;
      end else begin
        check_flag(busy_o, 1'b1, "busy during the run");
        valid_prev = check_valid_o;
        @(posedge c0_ddr4_clk);
        // Starts while busy must be ignored, so scramble them up to the last result
        if (noisy && results < count) begin
          r = $random(rand_seed);
          start_i        <= r[0];
          op_mode_i      <= test_mode_e'(r[1]);
          word_count_i   <= r[13:4];
          pattern_seed_i <= $random(rand_seed);
        end else begin
          start_i <= 1'b0;
        end
        @(negedge c0_ddr4_clk);
      end
    end
    err_expected = mism_seen;
    repeat (2) begin
      @(negedge c0_ddr4_clk);
      check_flag(done_o, 1'b0, "done is a single pulse");
      check_flag(busy_o, 1'b0, "busy after done");
      check_flag(data_compare_error_o, err_expected, "sticky error after the run");
    end
  endtask

  //**********************************************************
  // Sequence
  //**********************************************************
  initial begin : main_seq
    int            r;
    pattern_seed_t seed_a;
    int            count_a;
    c0_ddr4_clk    = 1'b0;
    rst_n_i        = 1'b0;
    start_i        = 1'b0;
    op_mode_i      = MODE_WRITE_READ;
    pattern_seed_i = '0;
    word_count_i   = '0;
    rand_seed      = 13890;
    err_expected   = 1'b0;
    budget_cycles  = 10 + CALIB_CYCLES;
    seed_a         = $random(rand_seed);
    count_a        = 1 + ({$random(rand_seed)} % 150);
    add_run(MODE_WRITE_READ, seed_a, count_a, 1'b0);
    add_run(MODE_READ_ONLY, seed_a, count_a, 1'b0);
    // Bit 0 always differs, so every word mismatches
    add_run(MODE_READ_ONLY, seed_a ^ (pattern_seed_t'($random(rand_seed)) | 32'h1), count_a,
            1'b0);
    add_run(MODE_WRITE_READ, $random(rand_seed), 300, 1'b1);
    repeat (4) begin
      r = $random(rand_seed);
      if (r[0]) begin
        add_run(MODE_READ_ONLY, $random(rand_seed), 1 + ({$random(rand_seed)} % 300), 1'b1);
      end else begin
        add_run(MODE_WRITE_READ, $random(rand_seed), 1 + ({$random(rand_seed)} % 200), 1'b1);
      end
    end
    budget_ready = 1'b1;

    repeat (10) @(posedge c0_ddr4_clk);
    rst_n_i <= 1'b1;
    // Starts during calibration must not be taken
    for (int cyc = 1; cyc <= CALIB_CYCLES; cyc++) begin
      @(posedge c0_ddr4_clk);
      r = $random(rand_seed);
      start_i <= (cyc < CALIB_CYCLES) ? r[0] : 1'b0;
      @(negedge c0_ddr4_clk);
      check_flag(init_calib_complete_o, cyc >= CALIB_CYCLES, "calibration complete timing");
      check_flag(busy_o, 1'b0, "start taken before calibration");
    end

    foreach (run_mode_q[i]) begin
      run_test(run_mode_q[i], run_seed_q[i], run_count_q[i], run_noisy_q[i]);
    end
    $display("Testbench passed");
    $finish;
  end

  initial begin : watchdog
    wait (budget_ready);
    repeat (budget_cycles) @(posedge c0_ddr4_clk);
    $display("Timeout: the runs did not complete within %0d clock cycles", budget_cycles);
    $display("Testbench failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== verilog/ddr_app_mem.sv ====
// Memory controller stand-in with refresh stalls and fixed read latency
`timescale 1ns/1ps

module ddr_app_mem (
  input  logic                  c0_ddr4_clk,
  input  logic                  rst_n_i,
  input  logic                  app_en_i,
  input  ddr_app_pkg::app_req_t app_req_i,
  output logic                  app_rdy_o,
  output logic                  rd_valid_o,
  output ddr_app_pkg::app_rsp_t rd_rsp_o
);
  import ddr_app_pkg::*;

  logic [REFRESH_CNT_WIDTH-1:0] ref_cnt;
  logic                         wr_accept;
  logic                         rd_accept;

  // Stages ahead of the final registered read
  logic [READ_LATENCY-2:0]      pipe_vld;
  app_addr_t                    pipe_addr [READ_LATENCY-1];

  app_data_t                    mem [MEM_DEPTH];

  //**********************************************************
  // Refresh window
  //**********************************************************
  always_ff @(posedge c0_ddr4_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ref_cnt <= '0;
    end else if (ref_cnt == REFRESH_CNT_WIDTH'(REFRESH_PERIOD - 1)) begin
      ref_cnt <= '0;
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  // Not ready while refresh occupies the start of the window
  assign app_rdy_o = (ref_cnt >= REFRESH_CNT_WIDTH'(REFRESH_LEN));

  assign wr_accept = app_en_i && app_rdy_o && (app_req_i.cmd == APP_CMD_WRITE);
  assign rd_accept = app_en_i && app_rdy_o && (app_req_i.cmd == APP_CMD_READ);

  //**********************************************************
  // Read pipeline
  //**********************************************************
  always_ff @(posedge c0_ddr4_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pipe_vld   <= '0;
      rd_valid_o <= 1'b0;
    end else begin
      pipe_vld[0] <= rd_accept;
      for (int i = 1; i < READ_LATENCY - 1; i++) begin
        pipe_vld[i] <= pipe_vld[i-1];
      end
      rd_valid_o <= pipe_vld[READ_LATENCY-2];
    end
  end

  // Address follows the valid bits; only valid stages matter
  always_ff @(posedge c0_ddr4_clk) begin
    pipe_addr[0] <= app_req_i.addr;
    for (int i = 1; i < READ_LATENCY - 1; i++) begin
      pipe_addr[i] <= pipe_addr[i-1];
    end
  end

  //**********************************************************
  // Storage
  //**********************************************************
  // Contents survive between runs, so a later read-only pass sees them
  always_ff @(posedge c0_ddr4_clk) begin
    if (wr_accept) begin
      mem[app_req_i.addr] <= app_req_i.wdata;
    end
  end

  // Array read at the last stage
  always_ff @(posedge c0_ddr4_clk) begin
    rd_rsp_o.addr  <= pipe_addr[READ_LATENCY-2];
    rd_rsp_o.rdata <= mem[pipe_addr[READ_LATENCY-2]];
  end

endmodule

// ==== verilog/ddr_app_pkg.sv ====
// DDR4 application interface types and memory stand-in sizing

package ddr_app_pkg;

  //**********************************************************
  // Memory geometry
  //**********************************************************
  localparam int APP_ADDR_WIDTH = 10;
  localparam int APP_DATA_WIDTH = 64;
  localparam int MEM_DEPTH      = 1024;

  //**********************************************************
  // Controller timing of the stand-in
  //**********************************************************
  // Cycles from read acceptance to read-valid
  localparam int READ_LATENCY      = 3;
  // Refresh window, with app_rdy low at the start of each one
  localparam int REFRESH_PERIOD    = 64;
  localparam int REFRESH_LEN       = 4;
  localparam int REFRESH_CNT_WIDTH = $clog2(REFRESH_PERIOD);

  typedef logic [APP_ADDR_WIDTH-1:0] app_addr_t;
  typedef logic [APP_DATA_WIDTH-1:0] app_data_t;

  // Reduced command set, write and read only
  typedef enum logic {
    APP_CMD_WRITE = 1'b0,
    APP_CMD_READ  = 1'b1
  } app_cmd_e;

  // Request as presented with app_en
  typedef struct packed {
    app_cmd_e  cmd;
    app_addr_t addr;
    app_data_t wdata;
  } app_req_t;

  // Read return, address travels with the data
  typedef struct packed {
    app_addr_t addr;
    app_data_t rdata;
  } app_rsp_t;

endpackage

// ==== verilog/ddr_calib_seq.sv ====
// Calibration sequencer, holds off traffic for a fixed time after reset
`timescale 1ns/1ps

module ddr_calib_seq (
  input  logic c0_ddr4_clk,
  input  logic rst_n_i,
  output logic calib_done_o
);
  import ddr_test_pkg::*;

  logic [CALIB_CNT_WIDTH-1:0] calib_cnt;

  // Saturating count, done rises on the CALIB_CYCLES-th edge after reset
  always_ff @(posedge c0_ddr4_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      calib_cnt    <= '0;
      calib_done_o <= 1'b0;
    end else if (!calib_done_o) begin
      if (calib_cnt == CALIB_CNT_WIDTH'(CALIB_CYCLES - 1)) begin
        calib_done_o <= 1'b1;
      end else begin
        calib_cnt <= calib_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== verilog/ddr_rd_checker.sv ====
// Read checker, compares returned data with the seeded pattern
`timescale 1ns/1ps

module ddr_rd_checker (
  input  logic                        c0_ddr4_clk,
  input  logic                        rst_n_i,
  input  logic                        run_start_i,
  input  ddr_test_pkg::pattern_seed_t run_seed_i,
  input  logic                        reads_issued_last_i,
  input  logic                        rd_valid_i,
  input  ddr_app_pkg::app_rsp_t       rd_rsp_i,
  output logic                        check_valid_o,
  output ddr_test_pkg::chk_result_t   check_o,
  output logic                        error_o,
  output logic                        run_done_o
);
  import ddr_app_pkg::*;
  import ddr_test_pkg::*;

  app_data_t               expected;
  logic                    mismatch;
  // Tracks the final read through the fixed-latency return path
  logic [READ_LATENCY-1:0] last_dly;
  logic                    last_ret;
  logic                    last_chk_q;

  assign expected = pattern_word(run_seed_i, rd_rsp_i.addr);
  assign mismatch = (rd_rsp_i.rdata != expected);

  // Final read of the run is returning now
  assign last_ret = last_dly[READ_LATENCY-1] && rd_valid_i;

  always_ff @(posedge c0_ddr4_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      check_valid_o <= 1'b0;
      error_o       <= 1'b0;
      last_dly      <= '0;
      last_chk_q    <= 1'b0;
      run_done_o    <= 1'b0;
    end else begin
      check_valid_o <= rd_valid_i;
      last_chk_q    <= last_ret;
      // Done one cycle after the last result is out
      run_done_o    <= check_valid_o && last_chk_q;
      last_dly[0]   <= reads_issued_last_i;
      for (int i = 1; i < READ_LATENCY; i++) begin
        last_dly[i] <= last_dly[i-1];
      end
      // New run clears the sticky error
      if (run_start_i) begin
        error_o  <= 1'b0;
        last_dly <= '0;
      end else if (rd_valid_i && mismatch) begin
        error_o <= 1'b1;
      end
    end
  end

  // Result holds until the next return
  always_ff @(posedge c0_ddr4_clk) begin
    if (rd_valid_i) begin
      check_o.addr     <= rd_rsp_i.addr;
      check_o.rdata    <= rd_rsp_i.rdata;
      check_o.expected <= expected;
      check_o.mismatch <= mismatch;
    end
  end

endmodule

// ==== verilog/ddr_test_pkg.sv ====
// Memory test types, pattern generation and test timing

package ddr_test_pkg;
  import ddr_app_pkg::*;

  // Calibration hold-off after reset release
  localparam int CALIB_CYCLES    = 64;
  localparam int CALIB_CNT_WIDTH = $clog2(CALIB_CYCLES);

  typedef enum logic {
    MODE_WRITE_READ = 1'b0,
    MODE_READ_ONLY  = 1'b1
  } test_mode_e;

  typedef logic [31:0] pattern_seed_t;

  // One compare of a returned read
  typedef struct packed {
    app_addr_t addr;
    app_data_t rdata;
    app_data_t expected;
    logic      mismatch;
  } chk_result_t;

  // Upper half is seed XOR address, lower half is inverted seed plus address
  function automatic app_data_t pattern_word(pattern_seed_t seed, app_addr_t addr);
    logic [31:0] addr_ext;
    addr_ext = 32'(addr);
    return {seed ^ addr_ext, (~seed) + addr_ext};
  endfunction

endpackage

// ==== verilog/ddr_test_top.sv ====
// Memory test subsystem top, calibration, traffic, memory model and checker
`timescale 1ns/1ps

module ddr_test_top (
  input  logic                        c0_ddr4_clk,
  input  logic                        rst_n_i,
  input  logic                        start_i,
  input  ddr_test_pkg::test_mode_e    op_mode_i,
  input  ddr_test_pkg::pattern_seed_t pattern_seed_i,
  input  ddr_app_pkg::app_addr_t      word_count_i,
  output logic                        init_calib_complete_o,
  output logic                        busy_o,
  output logic                        done_o,
  output logic                        data_compare_error_o,
  output logic                        check_valid_o,
  output ddr_test_pkg::chk_result_t   check_o
);
  import ddr_app_pkg::*;
  import ddr_test_pkg::*;

  // Application interface
  logic          app_en;
  logic          app_rdy;
  app_req_t      app_req;
  logic          rd_valid;
  app_rsp_t      rd_rsp;

  // Run control towards the checker
  logic          run_start;
  pattern_seed_t run_seed;
  logic          reads_issued_last;

  //**********************************************************
  // Calibration and traffic
  //**********************************************************
  ddr_calib_seq u_calib_seq (
    .c0_ddr4_clk  (c0_ddr4_clk),
    .rst_n_i      (rst_n_i),
    .calib_done_o (init_calib_complete_o)
  );

  ddr_traffic_gen u_traffic_gen (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .rst_n_i             (rst_n_i),
    .calib_done_i        (init_calib_complete_o),
    .start_i             (start_i),
    .op_mode_i           (op_mode_i),
    .pattern_seed_i      (pattern_seed_i),
    .word_count_i        (word_count_i),
    .app_rdy_i           (app_rdy),
    .run_done_i          (done_o),
    .app_en_o            (app_en),
    .app_req_o           (app_req),
    .run_start_o         (run_start),
    .run_seed_o          (run_seed),
    .reads_issued_last_o (reads_issued_last),
    .busy_o              (busy_o)
  );

  //**********************************************************
  // Memory and checking
  //**********************************************************
  ddr_app_mem u_app_mem (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n_i     (rst_n_i),
    .app_en_i    (app_en),
    .app_req_i   (app_req),
    .app_rdy_o   (app_rdy),
    .rd_valid_o  (rd_valid),
    .rd_rsp_o    (rd_rsp)
  );

  ddr_rd_checker u_rd_checker (
    .c0_ddr4_clk         (c0_ddr4_clk),
    .rst_n_i             (rst_n_i),
    .run_start_i         (run_start),
    .run_seed_i          (run_seed),
    .reads_issued_last_i (reads_issued_last),
    .rd_valid_i          (rd_valid),
    .rd_rsp_i            (rd_rsp),
    .check_valid_o       (check_valid_o),
    .check_o             (check_o),
    .error_o             (data_compare_error_o),
    .run_done_o          (done_o)
  );

endmodule

// ==== verilog/ddr_traffic_gen.sv ====
// Traffic generator, writes a seeded pattern over a region and reads it back
`timescale 1ns/1ps

module ddr_traffic_gen (
  input  logic                       c0_ddr4_clk,
  input  logic                       rst_n_i,
  input  logic                       calib_done_i,
  input  logic                       start_i,
  input  ddr_test_pkg::test_mode_e    op_mode_i,
  input  ddr_test_pkg::pattern_seed_t pattern_seed_i,
  input  ddr_app_pkg::app_addr_t      word_count_i,
  input  logic                       app_rdy_i,
  input  logic                       run_done_i,
  output logic                       app_en_o,
  output ddr_app_pkg::app_req_t       app_req_o,
  output logic                       run_start_o,
  output ddr_test_pkg::pattern_seed_t run_seed_o,
  output logic                       reads_issued_last_o,
  output logic                       busy_o
);
  import ddr_app_pkg::*;
  import ddr_test_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_READ,
    ST_WAIT
  } gen_state_e;

  gen_state_e    state_q;
  app_addr_t     addr_q;
  app_addr_t     last_addr_q;
  pattern_seed_t seed_q;
  logic          start_accept;
  logic          cmd_accept;
  logic          at_last;

  // Busy drops together with the done pulse from the checker
  assign busy_o       = (state_q != ST_IDLE) && !run_done_i;
  assign start_accept = calib_done_i && start_i && !busy_o;

  assign app_en_o   = (state_q == ST_WRITE) || (state_q == ST_READ);
  assign cmd_accept = app_en_o && app_rdy_i;
  assign at_last    = (addr_q == last_addr_q);

  assign app_req_o.cmd   = (state_q == ST_WRITE) ? APP_CMD_WRITE : APP_CMD_READ;
  assign app_req_o.addr  = addr_q;
  assign app_req_o.wdata = pattern_word(seed_q, addr_q);

  assign run_start_o         = start_accept;
  assign run_seed_o          = seed_q;
  assign reads_issued_last_o = cmd_accept && (state_q == ST_READ) && at_last;

  //**********************************************************
  // Run control
  //**********************************************************
  always_ff @(posedge c0_ddr4_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      addr_q  <= '0;
    end else if (start_accept) begin
      state_q <= (op_mode_i == MODE_READ_ONLY) ? ST_READ : ST_WRITE;
      addr_q  <= '0;
    end else begin
      case (state_q)
        ST_WRITE: begin
          if (cmd_accept) begin
            if (at_last) begin
              state_q <= ST_READ;
              addr_q  <= '0;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        ST_READ: begin
          if (cmd_accept) begin
            if (at_last) begin
              state_q <= ST_WAIT;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        // Reads in flight, wait for the last compare
        ST_WAIT: begin
          if (run_done_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Run settings; a word count of zero wraps and covers the whole array
  always_ff @(posedge c0_ddr4_clk) begin
    if (start_accept) begin
      seed_q      <= pattern_seed_i;
      last_addr_q <= word_count_i - 1'b1;
    end
  end

endmodule
